//--- compile.f
hw/mem_axi_pkg.sv
hw/read_line_assembler.sv
hw/axi_read_ctrl.sv
hw/axi_write_ctrl.sv
hw/mem_axi_bridge.sv
verification/axi_slave_model.sv
verification/mem_axi_bridge_tb.sv

//--- Makefile
# Verilator simulation of the memory to AXI bridge

VERILATOR ?= verilator
TOP       ?= mem_axi_bridge_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mem_axi_bridge_tb.sv
`timescale 1ns/1ps

module mem_axi_bridge_tb;
    import mem_axi_pkg::*;

    localparam logic [ID_W-1:0] AXI_ID = 4'h3;

    // timeout budget from requests times beats times stall times margin
    localparam int N_OPS       = 40;
    localparam int MAX_BEATS   = 8;
    localparam int MAX_STALL   = 8;
    localparam int CYCLE_LIMIT = N_OPS * MAX_BEATS * MAX_STALL * 4;

    logic        clk;
    logic        rst_n;
    mem_rd_req_t rd_req_i;
    logic        rd_valid_i;
    logic        rd_ready_o;
    mem_line_u   rd_data_o;
    logic        rd_resp_valid_o;
    mem_wr_req_t wr_req_i;
    logic        wr_valid_i;
    logic        wr_ready_o;
    axi_ar_t     ar_o;
    logic        ar_valid_o;
    logic        ar_ready_i;
    axi_r_t      r_i;
    logic        r_valid_i;
    logic        r_ready_o;
    axi_aw_t     aw_o;
    logic        aw_valid_o;
    logic        aw_ready_i;
    axi_w_t      w_o;
    logic        w_valid_o;
    logic        w_ready_i;
    logic        b_valid_i;
    logic        b_ready_o;

    // expected memory contents
    logic [31:0] ref_mem [0:255];
    int          err_cnt;
    int          test_cnt;
    int          test_fail;
    int          cycle_cnt;

    mem_axi_bridge #(
        .AXI_ID(AXI_ID)
    ) mem_axi_bridge_i (
        .clk(clk), .rst_n(rst_n),
        .rd_req_i(rd_req_i), .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o),
        .rd_data_o(rd_data_o), .rd_resp_valid_o(rd_resp_valid_o),
        .wr_req_i(wr_req_i), .wr_valid_i(wr_valid_i), .wr_ready_o(wr_ready_o),
        .ar_o(ar_o), .ar_valid_o(ar_valid_o), .ar_ready_i(ar_ready_i),
        .r_i(r_i), .r_valid_i(r_valid_i), .r_ready_o(r_ready_o),
        .aw_o(aw_o), .aw_valid_o(aw_valid_o), .aw_ready_i(aw_ready_i),
        .w_o(w_o), .w_valid_o(w_valid_o), .w_ready_i(w_ready_i),
        .b_valid_i(b_valid_i), .b_ready_o(b_ready_o)
    );

    axi_slave_model slave_i (
        .clk(clk), .rst_n(rst_n),
        .ar_i(ar_o), .ar_valid_i(ar_valid_o), .ar_ready_o(ar_ready_i),
        .r_o(r_i), .r_valid_o(r_valid_i), .r_ready_i(r_ready_o),
        .aw_i(aw_o), .aw_valid_i(aw_valid_o), .aw_ready_o(aw_ready_i),
        .w_i(w_o), .w_valid_i(w_valid_o), .w_ready_o(w_ready_i),
        .b_valid_o(b_valid_i), .b_ready_i(b_ready_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a request never completed", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////
    // reference model

    function automatic logic [31:0] fill_word(input int i);
        return {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h33, 8'(i)};
    endfunction

    // one beat per word and a single beat for four bytes or fewer
    function automatic int beats_for(input mem_size_e size);
        int bytes;
        bytes = int'(size) + 1;
        if (bytes <= 4) return 1;
        return bytes / 4;
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] v;
        for (int i = 0; i < 8; i++) v[32*i +: 32] = $urandom();
        return v;
    endfunction

    function automatic mem_line_u ref_read(input logic [31:0] addr, input mem_size_e size);
        mem_line_u   raw;
        mem_line_u   res;
        logic [31:0] a;
        int          off;
        raw = '0;
        off = int'(addr[1:0]);
        for (int i = 0; i < beats_for(size); i++) begin
            a = addr + 32'(4 * i);
            raw.words[i] = ref_mem[a[9:2]];
        end
        for (int b = 0; b < 32; b++) begin
            res.bytes[b] = (b + off < 32) ? raw.bytes[b + off] : 8'h00;
        end
        return res;
    endfunction

    task automatic ref_write(input logic [31:0] addr, input mem_size_e size,
                             input logic [31:0] strb, input logic [LINE_W-1:0] data);
        logic [31:0] a;
        int          off;
        off = int'(addr[1:0]);
        for (int k = 0; k < beats_for(size); k++) begin
            a = addr + 32'(4 * k);
            // bytes pushed above the word are dropped
            for (int j = off; j < 4; j++) begin
                if (strb[4*k + j - off]) begin
                    ref_mem[a[9:2]][8*j +: 8] = data[32*k + 8*(j - off) +: 8];
                end
            end
        end
    endtask

    ////////////////////
    // compare tasks

    task automatic check_line(input string name, input mem_line_u got, input mem_line_u exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error ar_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error aw_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////
    // bus drivers

    task automatic do_read(input logic [31:0] addr, input mem_size_e size,
                           output mem_line_u line);
        int      n_ar;
        bit      done;
        axi_ar_t exp_ar;
        @(negedge clk);
        rd_req_i.addr = addr;
        rd_req_i.size = size;
        rd_valid_i    = 1'b1;
        @(posedge clk);
        while (!rd_ready_o) @(posedge clk);
        @(negedge clk);
        rd_valid_i = 1'b0;
        n_ar = 0;
        done = 0;
        while (!done) begin
            @(posedge clk);
            if (ar_valid_o && ar_ready_i) begin
                exp_ar.addr  = addr + 32'(4 * n_ar);
                exp_ar.id    = AXI_ID;
                exp_ar.len   = 8'd0;
                exp_ar.size  = 3'd2;
                exp_ar.burst = 2'b01;
                check_ar(ar_o, exp_ar);
                n_ar++;
            end
            if (rd_resp_valid_o) begin
                line = rd_data_o;
                done = 1;
            end
        end
        if (n_ar != beats_for(size)) begin
            err_cnt++;
            $display("read at %h issued %0d AR transfers instead of %0d",
                     addr, n_ar, beats_for(size));
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input mem_size_e size,
                            input logic [31:0] strb, input logic [LINE_W-1:0] data);
        int      n_aw;
        int      n_w;
        axi_aw_t exp_aw;
        @(negedge clk);
        wr_req_i.addr = addr;
        wr_req_i.size = size;
        wr_req_i.strb = strb;
        wr_req_i.data = data;
        wr_valid_i    = 1'b1;
        @(posedge clk);
        while (!wr_ready_o) @(posedge clk);
        @(negedge clk);
        wr_valid_i = 1'b0;
        n_aw = 0;
        n_w  = 0;
        do begin
            @(posedge clk);
            if (aw_valid_o && aw_ready_i) begin
                exp_aw.addr  = addr + 32'(4 * n_aw);
                exp_aw.id    = AXI_ID;
                exp_aw.len   = 8'd0;
                exp_aw.size  = (size == SIZE_B1) ? 3'd0 : (size == SIZE_B2) ? 3'd1 : 3'd2;
                exp_aw.burst = 2'b01;
                check_aw(aw_o, exp_aw);
                n_aw++;
            end
            if (w_valid_o && w_ready_i) begin
                check_bit("w_o.last", w_o.last, 1'b1);
                n_w++;
            end
        end while (!wr_ready_o);
        if (n_aw != beats_for(size) || n_w != beats_for(size)) begin
            err_cnt++;
            $display("write at %h issued %0d AW and %0d W transfers instead of %0d",
                     addr, n_aw, n_w, beats_for(size));
        end
    endtask

    task automatic read_and_check(input logic [31:0] addr, input mem_size_e size);
        mem_line_u got;
        do_read(addr, size, got);
        check_line("rd_data_o", got, ref_read(addr, size));
    endtask

    task automatic write_and_check(input logic [31:0] addr, input mem_size_e size,
                                   input logic [31:0] strb, input logic [LINE_W-1:0] data);
        do_write(addr, size, strb, data);
        ref_write(addr, size, strb, data);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    ////////////////////
    // directed tests

    task automatic test_reset();
        int e;
        e = err_cnt;
        @(posedge clk);
        check_bit("rd_ready_o", rd_ready_o, 1'b1);
        check_bit("wr_ready_o", wr_ready_o, 1'b1);
        check_bit("b_ready_o", b_ready_o, 1'b1);
        check_bit("ar_valid_o", ar_valid_o, 1'b0);
        check_bit("r_ready_o", r_ready_o, 1'b0);
        check_bit("aw_valid_o", aw_valid_o, 1'b0);
        check_bit("w_valid_o", w_valid_o, 1'b0);
        check_bit("rd_resp_valid_o", rd_resp_valid_o, 1'b0);
        end_test("after_reset", e);
    endtask

    task automatic test_single_reads();
        int e;
        e = err_cnt;
        for (int off = 0; off < 4; off++) begin
            read_and_check(32'h10 + 32'(off), SIZE_B1);
            read_and_check(32'h50 + 32'(off), SIZE_B2);
            read_and_check(32'h90 + 32'(off), SIZE_B4);
        end
        end_test("single_beat_reads", e);
    endtask

    task automatic test_multi_reads();
        int e;
        e = err_cnt;
        read_and_check(32'h100, SIZE_B8);
        read_and_check(32'h140, SIZE_B16);
        read_and_check(32'h180, SIZE_B32);
        end_test("multi_beat_reads", e);
    endtask

    task automatic test_small_writes();
        int e;
        e = err_cnt;
        for (int off = 0; off < 4; off++) begin
            write_and_check(32'h200 + 32'(off), SIZE_B1, 32'h1, rand_line());
            read_and_check(32'h200, SIZE_B4);
            write_and_check(32'h210 + 32'(off), SIZE_B2, 32'h3, rand_line());
            read_and_check(32'h210, SIZE_B4);
        end
        end_test("small_writes", e);
    endtask

    task automatic test_line_write();
        int e;
        e = err_cnt;
        write_and_check(32'h300, SIZE_B32, 32'h5a3c_f00f, rand_line());
        read_and_check(32'h300, SIZE_B32);
        end_test("line_write_readback", e);
    endtask

    task automatic test_concurrent();
        int e;
        e = err_cnt;
        fork
            read_and_check(32'h80, SIZE_B16);
            write_and_check(32'h3c0, SIZE_B8, 32'h0000_00c6, rand_line());
        join
        read_and_check(32'h3c0, SIZE_B8);
        end_test("read_write_together", e);
    endtask

    initial begin
        void'($urandom(67));
        err_cnt    = 0;
        test_cnt   = 0;
        test_fail  = 0;
        cycle_cnt  = 0;
        rst_n      = 1'b0;
        rd_req_i   = '0;
        rd_valid_i = 1'b0;
        wr_req_i   = '0;
        wr_valid_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]       = fill_word(i);
            slave_i.mem[i]   = ref_mem[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_single_reads();
        test_multi_reads();
        test_small_writes();
        test_line_write();
        test_concurrent();

        $display("tests run %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verification/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_axi_pkg::axi_ar_t  ar_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output mem_axi_pkg::axi_r_t   r_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    input  mem_axi_pkg::axi_aw_t  aw_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  mem_axi_pkg::axi_w_t   w_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i
);
    import mem_axi_pkg::*;

    // word memory, indexed by address bits [9:2]
    logic [31:0] mem [0:255];

    axi_ar_t     ar_q[$];
    logic [31:0] aw_q[$];
    axi_w_t      w_q[$];
    int          b_pending;
    logic        r_taken;
    logic        b_taken;

    initial begin
        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        r_valid_o  = 1'b0;
        b_valid_o  = 1'b0;
        r_o        = '0;
        b_pending  = 0;
        r_taken    = 1'b0;
        b_taken    = 1'b0;
    end

    ////////////////////
    // handshakes seen on the rising edge
    always @(posedge clk) begin
        logic [31:0] waddr;
        axi_w_t      wbeat;
        if (!rst_n) begin
            ar_q.delete();
            aw_q.delete();
            w_q.delete();
            b_pending = 0;
            r_taken   = 1'b0;
            b_taken   = 1'b0;
        end else begin
            if (ar_valid_i && ar_ready_o) ar_q.push_back(ar_i);
            if (aw_valid_i && aw_ready_o) aw_q.push_back(aw_i.addr);
            if (w_valid_i && w_ready_o) w_q.push_back(w_i);
            r_taken = r_valid_o && r_ready_i;
            b_taken = b_valid_o && b_ready_i;
            // apply a write once address and data are both here
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                waddr = aw_q.pop_front();
                wbeat = w_q.pop_front();
                for (int b = 0; b < 4; b++) begin
                    if (wbeat.strb[b]) begin
                        mem[waddr[9:2]][8*b +: 8] = wbeat.data[8*b +: 8];
                    end
                end
                b_pending++;
            end
        end
    end

    ////////////////////
    // outputs change on the falling edge
    always @(negedge clk) begin
        axi_ar_t a;
        if (!rst_n) begin
            ar_ready_o = 1'b0;
            aw_ready_o = 1'b0;
            w_ready_o  = 1'b0;
            r_valid_o  = 1'b0;
            b_valid_o  = 1'b0;
        end else begin
            // random stalls, ready about three cycles in four
            ar_ready_o = ($urandom_range(3) != 0);
            aw_ready_o = ($urandom_range(3) != 0);
            w_ready_o  = ($urandom_range(3) != 0);
            if (r_taken) begin
                r_valid_o = 1'b0;
                r_taken   = 1'b0;
            end
            if (!r_valid_o && ar_q.size() > 0 && $urandom_range(3) != 0) begin
                a         = ar_q.pop_front();
                r_o.id    = a.id;
                r_o.data  = mem[a.addr[9:2]];
                r_o.resp  = 2'b00;
                r_o.last  = 1'b1;
                r_valid_o = 1'b1;
            end
            if (b_taken) begin
                b_valid_o = 1'b0;
                b_taken   = 1'b0;
                b_pending--;
            end
            if (!b_valid_o && b_pending > 0 && $urandom_range(3) != 0) begin
                b_valid_o = 1'b1;
            end
        end
    end

endmodule

//--- hw/mem_axi_bridge.sv
`timescale 1ns/1ps

module mem_axi_bridge #(
    parameter logic [mem_axi_pkg::ID_W-1:0] AXI_ID = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // memory read side
    input  mem_axi_pkg::mem_rd_req_t  rd_req_i,
    input  logic                      rd_valid_i,
    output logic                      rd_ready_o,
    output mem_axi_pkg::mem_line_u    rd_data_o,
    output logic                      rd_resp_valid_o,

    // memory write side
    input  mem_axi_pkg::mem_wr_req_t  wr_req_i,
    input  logic                      wr_valid_i,
    output logic                      wr_ready_o,

    // axi master
    output mem_axi_pkg::axi_ar_t      ar_o,
    output logic                      ar_valid_o,
    input  logic                      ar_ready_i,
    input  mem_axi_pkg::axi_r_t       r_i,
    input  logic                      r_valid_i,
    output logic                      r_ready_o,
    output mem_axi_pkg::axi_aw_t      aw_o,
    output logic                      aw_valid_o,
    input  logic                      aw_ready_i,
    output mem_axi_pkg::axi_w_t       w_o,
    output logic                      w_valid_o,
    input  logic                      w_ready_i,
    input  logic                      b_valid_i,
    output logic                      b_ready_o
);

    // write addresses still waiting for their response
    logic [7:0] b_pending_q;

    axi_read_ctrl #(
        .AXI_ID(AXI_ID)
    ) axi_read_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_req_i       (rd_req_i),
        .rd_valid_i     (rd_valid_i),
        .rd_ready_o     (rd_ready_o),
        .rd_data_o      (rd_data_o),
        .rd_resp_valid_o(rd_resp_valid_o),
        .ar_o           (ar_o),
        .ar_valid_o     (ar_valid_o),
        .ar_ready_i     (ar_ready_i),
        .r_i            (r_i),
        .r_valid_i      (r_valid_i),
        .r_ready_o      (r_ready_o)
    );

    axi_write_ctrl #(
        .AXI_ID(AXI_ID)
    ) axi_write_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req_i  (wr_req_i),
        .wr_valid_i(wr_valid_i),
        .wr_ready_o(wr_ready_o),
        .aw_o      (aw_o),
        .aw_valid_o(aw_valid_o),
        .aw_ready_i(aw_ready_i),
        .w_o       (w_o),
        .w_valid_o (w_valid_o),
        .w_ready_i (w_ready_i)
    );

    // responses are always taken and never inspected
    assign b_ready_o = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_pending_q <= '0;
        end else begin
            b_pending_q <= b_pending_q + 8'(aw_valid_o & aw_ready_i)
                                       - 8'(b_valid_i & b_ready_o);
        end
    end

    // every B must answer an earlier AW
    a_b_after_aw: assert property (
        @(posedge clk) disable iff (!rst_n)
        b_valid_i |-> b_pending_q != 8'd0
    );

endmodule

//--- hw/axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl #(
    parameter logic [mem_axi_pkg::ID_W-1:0] AXI_ID = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_axi_pkg::mem_wr_req_t  wr_req_i,
    input  logic                      wr_valid_i,
    output logic                      wr_ready_o,
    output mem_axi_pkg::axi_aw_t      aw_o,
    output logic                      aw_valid_o,
    input  logic                      aw_ready_i,
    output mem_axi_pkg::axi_w_t       w_o,
    output logic                      w_valid_o,
    input  logic                      w_ready_i
);
    import mem_axi_pkg::*;

    typedef enum logic {
        WR_IDLE,
        WR_BUSY
    } wr_state_e;

    wr_state_e             state_q;
    mem_wr_req_t           req_q;
    logic                  aw_done_q;
    logic                  w_done_q;
    logic [BEAT_CNT_W-1:0] aw_cnt_q;
    logic [BEAT_CNT_W-1:0] w_cnt_q;
    logic [BEAT_CNT_W-1:0] last_idx;
    logic                  req_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  aw_fin;
    logic                  w_fin;
    logic [SIZE_W-1:0]     aw_size;
    logic [DATA_W-1:0]     word_sel;
    logic [DATA_W/8-1:0]   strb_sel;
    logic [1:0]            offset;

    assign last_idx   = last_beat(req_q.size);
    assign offset     = req_q.addr[1:0];
    assign wr_ready_o = (state_q == WR_IDLE);
    assign aw_valid_o = (state_q == WR_BUSY) && !aw_done_q;
    assign w_valid_o  = (state_q == WR_BUSY) && !w_done_q;

    assign req_fire = wr_valid_i & wr_ready_o;
    assign aw_fire  = aw_valid_o & aw_ready_i;
    assign w_fire   = w_valid_o & w_ready_i;

    // channel counts as finished once its last beat is taken
    assign aw_fin = aw_done_q | (aw_fire & (aw_cnt_q == last_idx));
    assign w_fin  = w_done_q | (w_fire & (w_cnt_q == last_idx));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= WR_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            aw_cnt_q  <= '0;
            w_cnt_q   <= '0;
        end else if (state_q == WR_IDLE) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            aw_cnt_q  <= '0;
            w_cnt_q   <= '0;
            if (req_fire) begin
                state_q <= WR_BUSY;
            end
        end else begin
            aw_done_q <= aw_fin;
            w_done_q  <= w_fin;
            if (aw_fire && !aw_fin) begin
                aw_cnt_q <= aw_cnt_q + 1'b1;
            end
            if (w_fire && !w_fin) begin
                w_cnt_q <= w_cnt_q + 1'b1;
            end
            if (aw_fin && w_fin) begin
                state_q <= WR_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= wr_req_i;
        end
    end

    ////////////////////
    // write address channel
    always_comb begin
        case (req_q.size)
            SIZE_B1: aw_size = AXI_SIZE_1B;
            SIZE_B2: aw_size = AXI_SIZE_2B;
            default: aw_size = AXI_SIZE_4B;
        endcase
    end

    always_comb begin
        aw_o.addr  = req_q.addr + ADDR_W'({aw_cnt_q, 2'b00});
        aw_o.id    = AXI_ID;
        aw_o.len   = '0;
        aw_o.size  = aw_size;
        aw_o.burst = AXI_BURST_INCR;
    end

    ////////////////////
    // write data channel
    // bytes pushed past the word by the offset are lost
    assign word_sel = req_q.data[w_cnt_q*DATA_W +: DATA_W];
    assign strb_sel = req_q.strb[w_cnt_q*(DATA_W/8) +: DATA_W/8];

    always_comb begin
        w_o.data = word_sel << {offset, 3'b000};
        w_o.strb = strb_sel << offset;
        w_o.last = 1'b1;
    end

    a_aw_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o)
    );

    a_w_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o)
    );

endmodule

//--- hw/axi_read_ctrl.sv
`timescale 1ns/1ps

module axi_read_ctrl #(
    parameter logic [mem_axi_pkg::ID_W-1:0] AXI_ID = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_axi_pkg::mem_rd_req_t  rd_req_i,
    input  logic                      rd_valid_i,
    output logic                      rd_ready_o,
    output mem_axi_pkg::mem_line_u    rd_data_o,
    output logic                      rd_resp_valid_o,
    output mem_axi_pkg::axi_ar_t      ar_o,
    output logic                      ar_valid_o,
    input  logic                      ar_ready_i,
    input  mem_axi_pkg::axi_r_t       r_i,
    input  logic                      r_valid_i,
    output logic                      r_ready_o
);
    import mem_axi_pkg::*;

    // AR beats go out in issue and R beats may already arrive
    // collect waits for the rest of R once every AR is sent
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_COLLECT
    } rd_state_e;

    rd_state_e             state_q;
    rd_state_e             state_d;
    mem_rd_req_t           req_q;
    logic [BEAT_CNT_W-1:0] ar_cnt_q;
    logic [BEAT_CNT_W-1:0] r_cnt_q;
    logic [BEAT_CNT_W-1:0] last_idx;
    logic                  req_fire;
    logic                  ar_fire;
    logic                  r_fire;
    logic                  ar_last;
    logic                  r_last;

    assign last_idx   = last_beat(req_q.size);
    assign rd_ready_o = (state_q == RD_IDLE);
    assign ar_valid_o = (state_q == RD_ISSUE);
    assign r_ready_o  = (state_q != RD_IDLE);

    assign req_fire = rd_valid_i & rd_ready_o;
    assign ar_fire  = ar_valid_o & ar_ready_i;
    assign r_fire   = r_valid_i & r_ready_o;
    assign ar_last  = (ar_cnt_q == last_idx);
    assign r_last   = (r_cnt_q == last_idx);

    // response pulses with the final beat
    assign rd_resp_valid_o = r_fire & r_last;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (req_fire) begin
                    state_d = RD_ISSUE;
                end
            end
            RD_ISSUE: begin
                if (ar_fire && ar_last) begin
                    state_d = RD_COLLECT;
                end
            end
            RD_COLLECT: begin
                state_d = RD_COLLECT;
            end
            default: begin
                state_d = RD_IDLE;
            end
        endcase
        if (r_fire && r_last) begin
            state_d = RD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= RD_IDLE;
            ar_cnt_q <= '0;
            r_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            if (req_fire) begin
                ar_cnt_q <= '0;
                r_cnt_q  <= '0;
            end else begin
                if (ar_fire && !ar_last) begin
                    ar_cnt_q <= ar_cnt_q + 1'b1;
                end
                if (r_fire && !r_last) begin
                    r_cnt_q <= r_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= rd_req_i;
        end
    end

    ////////////////////
    // one word per AR beat
    always_comb begin
        ar_o.addr  = req_q.addr + ADDR_W'({ar_cnt_q, 2'b00});
        ar_o.id    = AXI_ID;
        ar_o.len   = '0;
        ar_o.size  = AXI_SIZE_4B;
        ar_o.burst = AXI_BURST_INCR;
    end

    read_line_assembler read_line_assembler_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (req_fire),
        .beat_valid_i(r_fire),
        .beat_idx_i  (r_cnt_q),
        .offset_i    (req_q.addr[1:0]),
        .beat_data_i (r_i.data),
        .line_o      (rd_data_o)
    );

    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
    );

    // R beats never run ahead of the AR beats already sent
    a_r_cnt_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        r_fire |-> state_q == RD_COLLECT || r_cnt_q < ar_cnt_q
    );

endmodule

//--- hw/read_line_assembler.sv
`timescale 1ns/1ps

module read_line_assembler (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clear_i,
    input  logic                              beat_valid_i,
    input  logic [mem_axi_pkg::BEAT_CNT_W-1:0] beat_idx_i,
    input  logic [1:0]                        offset_i,
    input  logic [mem_axi_pkg::DATA_W-1:0]     beat_data_i,
    output mem_axi_pkg::mem_line_u            line_o
);
    import mem_axi_pkg::*;

    localparam int LINE_BYTES = LINE_W / 8;

    mem_line_u line_q;
    mem_line_u merged;

    // current beat dropped into its word slot
    always_comb begin
        merged = line_q;
        if (beat_valid_i) begin
            merged.words[beat_idx_i] = beat_data_i;
        end
    end

    // right shift by the request byte offset, zero fill at the top
    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (i + int'(offset_i) < LINE_BYTES) begin
                line_o.bytes[i] = merged.bytes[i + int'(offset_i)];
            end else begin
                line_o.bytes[i] = 8'h00;
            end
        end
    end

    // stored unshifted so later beats land in the right slot
    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            line_q <= '0;
        end else if (beat_valid_i) begin
            line_q <= merged;
        end
    end

endmodule

//--- hw/mem_axi_pkg.sv
package mem_axi_pkg;

    // bus widths
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_W     = 256;
    localparam int STRB_W     = 32;
    localparam int ID_W       = 4;
    localparam int BEAT_CNT_W = 3;

    // axi field widths
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    localparam logic [BURST_W-1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [SIZE_W-1:0]  AXI_SIZE_1B    = 3'd0;
    localparam logic [SIZE_W-1:0]  AXI_SIZE_2B    = 3'd1;
    localparam logic [SIZE_W-1:0]  AXI_SIZE_4B    = 3'd2;

    // request size codes, number of bytes minus one
    typedef enum logic [5:0] {
        SIZE_B1  = 6'h00,
        SIZE_B2  = 6'h01,
        SIZE_B4  = 6'h03,
        SIZE_B8  = 6'h07,
        SIZE_B16 = 6'h0f,
        SIZE_B32 = 6'h1f
    } mem_size_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        mem_size_e         size;
    } mem_rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        mem_size_e         size;
        logic [STRB_W-1:0] strb;
        logic [LINE_W-1:0] data;
    } mem_wr_req_t;

    // one line, seen as beat words or as bytes
    typedef union packed {
        logic [LINE_W/DATA_W-1:0][DATA_W-1:0] words;
        logic [LINE_W/8-1:0][7:0]             bytes;
    } mem_line_u;

    ////////////////////
    // axi channel payloads

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [ID_W-1:0]    id;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                last;
    } axi_w_t;

    // index of the final single-word beat for a size code
    function automatic logic [BEAT_CNT_W-1:0] last_beat(input mem_size_e size);
        case (size)
            SIZE_B8:  return BEAT_CNT_W'(1);
            SIZE_B16: return BEAT_CNT_W'(3);
            SIZE_B32: return BEAT_CNT_W'(7);
            default:  return BEAT_CNT_W'(0);
        endcase
    endfunction

endpackage
